// ==== build.f ====
design/tidc_pkg.sv
design/l1_request_queue.sv
design/l1_message_issuer.sv
design/tl_response_tracker.sv
design/l1_tilelink_adapter.sv
tests/l1_tilelink_adapter_assert.sv
tests/tb_l1_tilelink_adapter.sv

// ==== Makefile ====
TOP = tb_l1_tilelink_adapter

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Test completed successfully" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== tests/tb_l1_tilelink_adapter.sv ====
/*
 * Directed testbench for the L1 TileLink adapter
 */
`timescale 1ns/10ps

module tb_l1_tilelink_adapter;

    localparam logic [3:0] SRC        = 4'd3;
    localparam int         WAIT_LIMIT = 50;
    // Cycle budgets of the reset, read, write miss, write-back, queue and foreign source tests
    localparam int WATCHDOG_CYCLES = 100 + 300 + 300 + 400 + 600 + 300;

    typedef enum {REQ_READY, A_VALID, C_VALID, D_READY, E_VALID} wait_sig_e;

    logic clk, rst_n, l1_req_valid, l1_req_ready, fill_valid;
    logic a_valid, a_ready, c_valid, c_ready, d_valid, d_ready, e_valid, e_ready;
    logic [tidc_pkg::SINK_W-1:0] e_sink;
    tidc_pkg::l1_req_t   l1_req;
    tidc_pkg::l1_fill_t  fill;
    tidc_pkg::tl_a_msg_t a_msg;
    tidc_pkg::tl_c_msg_t c_msg;
    tidc_pkg::tl_d_msg_t d_msg;

    logic [15:0] lfsr_state;
    int          mismatches;
    int          timeouts;

    l1_tilelink_adapter #(.SOURCE_ID(SRC), .QUEUE_DEPTH(4)) dut (.*);

    bind l1_tilelink_adapter l1_tilelink_adapter_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Random bits and message builders
    // ==============================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[126:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic tidc_pkg::l1_req_t make_req(input tidc_pkg::l1_req_kind_e kind,
            input logic [31:0] addr, input logic [2:0] perm, input logic [127:0] data);
        tidc_pkg::l1_req_t r;
        r.kind = kind;
        r.addr = addr;
        r.perm = perm;
        r.data = data;
        return r;
    endfunction

    // AcquireBlock always asks for a whole line with every byte enabled
    function automatic tidc_pkg::tl_a_msg_t expect_acquire(input tidc_pkg::l1_req_t r);
        tidc_pkg::tl_a_msg_t m;
        m.opcode  = tidc_pkg::ACQUIRE_BLOCK;
        m.param   = r.perm;
        m.size    = 4'd4;
        m.source  = SRC;
        m.address = r.addr;
        m.mask    = 16'hFFFF;
        return m;
    endfunction

    function automatic tidc_pkg::tl_c_msg_t expect_release(input tidc_pkg::l1_req_t r);
        tidc_pkg::tl_c_msg_t m;
        m.opcode  = tidc_pkg::RELEASE_DATA;
        m.param   = r.perm;
        m.size    = 4'd4;
        m.source  = SRC;
        m.address = r.addr;
        m.data    = r.data;
        return m;
    endfunction

    function automatic tidc_pkg::tl_d_msg_t make_d(input tidc_pkg::d_opcode_e op,
            input logic [3:0] source, input logic [3:0] sink, input logic [127:0] data,
            input logic error);
        tidc_pkg::tl_d_msg_t m;
        m.opcode = op;
        m.param  = 3'd0;
        m.size   = 4'd4;
        m.source = source;
        m.sink   = sink;
        m.data   = data;
        m.error  = error;
        return m;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic compare_a(input tidc_pkg::tl_a_msg_t got, input tidc_pkg::tl_a_msg_t exp,
            input string what);
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_c(input tidc_pkg::tl_c_msg_t got, input tidc_pkg::tl_c_msg_t exp,
            input string what);
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_fill(input tidc_pkg::l1_fill_t got, input tidc_pkg::l1_fill_t exp,
            input string what);
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_sink(input logic [tidc_pkg::SINK_W-1:0] got,
            input logic [tidc_pkg::SINK_W-1:0] exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatches++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // ==============================
    // Channel drivers
    // ==============================
    function automatic logic sig_level(input wait_sig_e which);
        case (which)
            REQ_READY: return l1_req_ready;
            A_VALID:   return a_valid;
            C_VALID:   return c_valid;
            D_READY:   return d_ready;
            default:   return e_valid;
        endcase
    endfunction

    task automatic wait_high(input wait_sig_e which, input string what);
        int n;
        n = 0;
        while (!sig_level(which) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!sig_level(which)) begin
            timeouts++;
            $display("Gave up waiting for %s after %0d cycles", what, WAIT_LIMIT);
        end
    endtask

    task automatic send_req(input tidc_pkg::l1_req_t r);
        wait_high(REQ_READY, "l1_req_ready");
        l1_req_valid = 1'b1;
        l1_req       = r;
        @(negedge clk);
        l1_req_valid = 1'b0;
    endtask

    task automatic take_a(input tidc_pkg::tl_a_msg_t exp);
        wait_high(A_VALID, "an Acquire on channel A");
        compare_a(a_msg, exp, "Acquire message");
        a_ready = 1'b1;
        @(negedge clk);
        a_ready = 1'b0;
    endtask

    task automatic take_c(input tidc_pkg::tl_c_msg_t exp);
        wait_high(C_VALID, "a ReleaseData on channel C");
        compare_c(c_msg, exp, "ReleaseData message");
        c_ready = 1'b1;
        @(negedge clk);
        c_ready = 1'b0;
    endtask

    // Returns on the falling edge just after the beat was taken
    task automatic send_d(input tidc_pkg::tl_d_msg_t m);
        wait_high(D_READY, "d_ready");
        d_valid = 1'b1;
        d_msg   = m;
        @(negedge clk);
        d_valid = 1'b0;
    endtask

    task automatic take_e(input logic [3:0] exp_sink);
        wait_high(E_VALID, "a GrantAck on channel E");
        compare_sink(e_sink, exp_sink, "GrantAck sink");
        e_ready = 1'b1;
        @(negedge clk);
        e_ready = 1'b0;
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic test_reset_state();
        compare_flag(a_valid, 1'b0, "a_valid after reset");
        compare_flag(c_valid, 1'b0, "c_valid after reset");
        compare_flag(e_valid, 1'b0, "e_valid after reset");
        compare_flag(fill_valid, 1'b0, "fill_valid after reset");
        compare_flag(l1_req_ready, 1'b1, "l1_req_ready after reset");
        compare_flag(d_ready, 1'b1, "d_ready after reset");
    endtask

    task automatic test_read_miss();
        logic [127:0]       bits;
        tidc_pkg::l1_req_t  req;
        tidc_pkg::l1_fill_t exp_fill;
        logic [3:0]         sink;
        take_bits(128, bits);
        req = make_req(tidc_pkg::READ_MISS, 32'h1000_0040, 3'd1, bits);
        send_req(req);
        take_a(expect_acquire(req));
        take_bits(128, bits);
        exp_fill.data = bits;
        take_bits(1, bits);
        exp_fill.error = bits[0];
        take_bits(4, bits);
        sink = bits[3:0];
        send_d(make_d(tidc_pkg::GRANT_DATA, SRC, sink, exp_fill.data, exp_fill.error));
        compare_flag(fill_valid, 1'b1, "fill strobe on GrantData");
        compare_fill(fill, exp_fill, "GrantData fill");
        take_e(sink);
    endtask

    task automatic test_write_miss_grant();
        logic [127:0]      bits;
        tidc_pkg::l1_req_t req;
        logic [3:0]        sink;
        take_bits(128, bits);
        req = make_req(tidc_pkg::WRITE_MISS, 32'h1000_1230, 3'd2, bits);
        send_req(req);
        take_a(expect_acquire(req));
        take_bits(4, bits);
        sink = bits[3:0];
        send_d(make_d(tidc_pkg::GRANT, SRC, sink, '0, 1'b0));
        compare_flag(fill_valid, 1'b0, "fill strobe on plain Grant");
        take_e(sink);
    endtask

    task automatic test_write_back();
        logic [127:0]      bits;
        tidc_pkg::l1_req_t wb;
        tidc_pkg::l1_req_t rd;
        take_bits(128, bits);
        wb = make_req(tidc_pkg::WRITE_BACK, 32'h3000_0080, 3'd5, bits);
        take_bits(128, bits);
        rd = make_req(tidc_pkg::READ_MISS, 32'h3000_0100, 3'd0, bits);
        send_req(wb);
        send_req(rd);
        take_c(expect_release(wb));
        // The queued miss must wait for ReleaseAck
        repeat (4) @(negedge clk);
        compare_flag(a_valid, 1'b0, "Acquire issued before ReleaseAck");
        send_d(make_d(tidc_pkg::RELEASE_ACK, SRC, 4'd0, '0, 1'b0));
        take_a(expect_acquire(rd));
        send_d(make_d(tidc_pkg::GRANT, SRC, 4'd7, '0, 1'b0));
        take_e(4'd7);
    endtask

    task automatic test_backpressure_and_queue();
        logic [127:0]      bits;
        tidc_pkg::l1_req_t reqs [5];
        for (int i = 0; i < 5; i++) begin
            take_bits(128, bits);
            reqs[i] = make_req(tidc_pkg::READ_MISS, 32'h2000_0000 + 32'(i) * 32'd16,
                               3'(i), bits);
            send_req(reqs[i]);
        end
        // One request sits in the issuer, four fill the queue
        compare_flag(l1_req_ready, 1'b0, "l1_req_ready with queue full");
        for (int i = 0; i < 5; i++) begin
            take_a(expect_acquire(reqs[i]));
            send_d(make_d(tidc_pkg::GRANT, SRC, 4'(i + 8), '0, 1'b0));
            take_e(4'(i + 8));
        end
    endtask

    task automatic test_foreign_source();
        logic [127:0]      bits;
        tidc_pkg::l1_req_t req;
        take_bits(128, bits);
        req = make_req(tidc_pkg::WRITE_MISS, 32'h4000_0010, 3'd1, bits);
        send_req(req);
        take_a(expect_acquire(req));
        send_d(make_d(tidc_pkg::GRANT_DATA, 4'd5, 4'd2, bits, 1'b0));
        compare_flag(fill_valid, 1'b0, "fill on foreign source");
        compare_flag(e_valid, 1'b0, "GrantAck on foreign source");
        send_d(make_d(tidc_pkg::GRANT, SRC, 4'd9, '0, 1'b0));
        compare_flag(e_valid, 1'b1, "GrantAck after matching Grant");
        take_e(4'd9);
    endtask

    // ==============================
    // Run control
    // ==============================
    task automatic finish_run(input bit timed_out);
        int assert_fails;
        assert_fails = dut.u_assert.failures;
        $display("Summary: %0d mismatches, %0d wait timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (!timed_out && mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running",
                 WATCHDOG_CYCLES);
        finish_run(1'b1);
    end

    initial begin
        lfsr_state   = 16'd50;
        mismatches   = 0;
        timeouts     = 0;
        rst_n        = 1'b0;
        l1_req_valid = 1'b0;
        l1_req       = '0;
        a_ready      = 1'b0;
        c_ready      = 1'b0;
        d_valid      = 1'b0;
        d_msg        = '0;
        e_ready      = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_read_miss();
        test_write_miss_grant();
        test_write_back();
        test_backpressure_and_queue();
        test_foreign_source();
        finish_run(1'b0);
    end

endmodule

// ==== tests/l1_tilelink_adapter_assert.sv ====
/*
 * Concurrent checks on adapter handshakes and reset values
 */
`timescale 1ns/10ps

module l1_tilelink_adapter_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        a_valid,
    input tidc_pkg::tl_a_msg_t         a_msg,
    input logic                        a_ready,
    input logic                        c_valid,
    input logic                        e_valid,
    input logic [tidc_pkg::SINK_W-1:0] e_sink,
    input logic                        e_ready,
    input logic                        fill_valid,
    input logic                        l1_req_ready,
    input logic                        d_ready
);

    // Assertion failures seen so far
    int failures = 0;

    // Acquire holds until the network takes it
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && !a_ready |=> a_valid && $stable(a_msg))
        else begin
            failures++;
            $error("Channel A changed while a_ready was low");
        end

    e_hold: assert property (@(posedge clk) disable iff (!rst_n)
        e_valid && !e_ready |=> e_valid && $stable(e_sink))
        else begin
            failures++;
            $error("Channel E changed while e_ready was low");
        end

    fill_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        fill_valid |=> !fill_valid)
        else begin
            failures++;
            $error("fill_valid lasted more than one cycle");
        end

    reset_quiet: assert property (@(posedge clk) !rst_n |->
        !a_valid && !c_valid && !e_valid && !fill_valid && l1_req_ready && d_ready)
        else begin
            failures++;
            $error("Outputs not at their idle values during reset");
        end

endmodule

// ==== design/l1_tilelink_adapter.sv ====
/*
 * L1 TileLink adapter top
 * Queues L1 requests and runs them one at a time over channels A, C, D and E
 */
`timescale 1ns/10ps

module l1_tilelink_adapter #(
    parameter logic [tidc_pkg::SOURCE_W-1:0] SOURCE_ID   = '0,
    parameter int                            QUEUE_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // L1 side
    input  logic                          l1_req_valid,
    input  tidc_pkg::l1_req_t             l1_req,
    output logic                          l1_req_ready,
    output logic                          fill_valid,
    output tidc_pkg::l1_fill_t            fill,
    // TileLink side
    output logic                          a_valid,
    output tidc_pkg::tl_a_msg_t           a_msg,
    input  logic                          a_ready,
    output logic                          c_valid,
    output tidc_pkg::tl_c_msg_t           c_msg,
    input  logic                          c_ready,
    input  logic                          d_valid,
    input  tidc_pkg::tl_d_msg_t           d_msg,
    output logic                          d_ready,
    output logic                          e_valid,
    output logic [tidc_pkg::SINK_W-1:0]   e_sink,
    input  logic                          e_ready
);

    logic              q_valid;
    logic              q_pop;
    tidc_pkg::l1_req_t q_head;
    logic              wait_grant;
    logic              wait_release;
    logic              txn_done;

    l1_request_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .l1_req_valid (l1_req_valid),
        .l1_req       (l1_req),
        .l1_req_ready (l1_req_ready),
        .q_pop        (q_pop),
        .q_valid      (q_valid),
        .q_head       (q_head)
    );

    l1_message_issuer #(
        .SOURCE_ID (SOURCE_ID)
    ) u_issuer (
        .clk          (clk),
        .rst_n        (rst_n),
        .q_valid      (q_valid),
        .q_head       (q_head),
        .q_pop        (q_pop),
        .a_valid      (a_valid),
        .a_msg        (a_msg),
        .a_ready      (a_ready),
        .c_valid      (c_valid),
        .c_msg        (c_msg),
        .c_ready      (c_ready),
        .wait_grant   (wait_grant),
        .wait_release (wait_release),
        .txn_done     (txn_done)
    );

    tl_response_tracker #(
        .SOURCE_ID (SOURCE_ID)
    ) u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .wait_grant   (wait_grant),
        .wait_release (wait_release),
        .d_valid      (d_valid),
        .d_msg        (d_msg),
        .d_ready      (d_ready),
        .e_valid      (e_valid),
        .e_sink       (e_sink),
        .e_ready      (e_ready),
        .fill_valid   (fill_valid),
        .fill         (fill),
        .txn_done     (txn_done)
    );

endmodule

// ==== design/tl_response_tracker.sv ====
/*
 * Response tracker
 * Checks channel D beats, delivers fills, sends GrantAck on E and flags completion
 */
`timescale 1ns/10ps

module tl_response_tracker #(
    parameter logic [tidc_pkg::SOURCE_W-1:0] SOURCE_ID = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wait_grant,
    input  logic                          wait_release,
    input  logic                          d_valid,
    input  tidc_pkg::tl_d_msg_t           d_msg,
    output logic                          d_ready,
    output logic                          e_valid,
    output logic [tidc_pkg::SINK_W-1:0]   e_sink,
    input  logic                          e_ready,
    output logic                          fill_valid,
    output tidc_pkg::l1_fill_t            fill,
    output logic                          txn_done
);

    logic d_fire;
    logic src_match;
    logic is_grant;
    logic grant_hit;
    logic release_hit;
    logic release_done;

    // D stalls only while a GrantAck is still pending on E
    assign d_ready   = !e_valid;
    assign d_fire    = d_valid && d_ready;
    assign src_match = (d_msg.source == SOURCE_ID);
    assign is_grant  = (d_msg.opcode == tidc_pkg::GRANT) ||
                       (d_msg.opcode == tidc_pkg::GRANT_DATA);

    // Anything else on D is taken and dropped
    assign grant_hit   = d_fire && wait_grant && src_match && is_grant;
    assign release_hit = d_fire && wait_release && src_match && !release_done &&
                         (d_msg.opcode == tidc_pkg::RELEASE_ACK);

    assign txn_done = (e_valid && e_ready) || release_done;

    // ==============================
    // Payload registers
    // ==============================
    always_ff @(posedge clk) begin
        if (grant_hit) begin
            e_sink     <= d_msg.sink;
            fill.data  <= d_msg.data;
            fill.error <= d_msg.error;
        end
    end

    // ==============================
    // Handshake state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid      <= 1'b0;
            fill_valid   <= 1'b0;
            release_done <= 1'b0;
        end else begin
            // Fill is a single-cycle strobe
            fill_valid   <= grant_hit && (d_msg.opcode == tidc_pkg::GRANT_DATA);
            release_done <= release_hit;

            if (grant_hit) begin
                e_valid <= 1'b1;
            end else if (e_ready) begin
                e_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== design/l1_message_issuer.sv ====
/*
 * Message issuer
 * Turns the queue head into AcquireBlock or ReleaseData, one transaction at a time
 */
`timescale 1ns/10ps

module l1_message_issuer #(
    parameter logic [tidc_pkg::SOURCE_W-1:0] SOURCE_ID = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                q_valid,
    input  tidc_pkg::l1_req_t   q_head,
    output logic                q_pop,
    output logic                a_valid,
    output tidc_pkg::tl_a_msg_t a_msg,
    input  logic                a_ready,
    output logic                c_valid,
    output tidc_pkg::tl_c_msg_t c_msg,
    input  logic                c_ready,
    output logic                wait_grant,
    output logic                wait_release,
    input  logic                txn_done
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_A,
        SEND_C,
        WAIT_GRANT,
        WAIT_RELEASE
    } state_e;

    state_e state;

    // Head is taken the same cycle it shows up while idle
    assign q_pop        = (state == IDLE) && q_valid;
    assign wait_grant   = (state == WAIT_GRANT);
    assign wait_release = (state == WAIT_RELEASE);

    // ==============================
    // Message payload
    // ==============================
    always_ff @(posedge clk) begin
        if (q_pop) begin
            a_msg.opcode  <= tidc_pkg::ACQUIRE_BLOCK;
            a_msg.param   <= q_head.perm;
            a_msg.size    <= tidc_pkg::LINE_SIZE_LOG2;
            a_msg.source  <= SOURCE_ID;
            a_msg.address <= q_head.addr;
            a_msg.mask    <= '1;

            c_msg.opcode  <= tidc_pkg::RELEASE_DATA;
            c_msg.param   <= q_head.perm;
            c_msg.size    <= tidc_pkg::LINE_SIZE_LOG2;
            c_msg.source  <= SOURCE_ID;
            c_msg.address <= q_head.addr;
            c_msg.data    <= q_head.data;
        end
    end

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            a_valid <= 1'b0;
            c_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (q_valid) begin
                        case (q_head.kind)
                            tidc_pkg::READ_MISS,
                            tidc_pkg::WRITE_MISS: begin
                                a_valid <= 1'b1;
                                state   <= SEND_A;
                            end
                            tidc_pkg::WRITE_BACK: begin
                                c_valid <= 1'b1;
                                state   <= SEND_C;
                            end
                            // Unknown kinds are popped and dropped
                            default: state <= IDLE;
                        endcase
                    end
                end
                SEND_A: begin
                    if (a_ready) begin
                        a_valid <= 1'b0;
                        state   <= WAIT_GRANT;
                    end
                end
                SEND_C: begin
                    if (c_ready) begin
                        c_valid <= 1'b0;
                        state   <= WAIT_RELEASE;
                    end
                end
                WAIT_GRANT, WAIT_RELEASE: begin
                    if (txn_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/l1_request_queue.sv ====
/*
 * L1 request queue
 * Circular FIFO holding L1 misses and write-backs until the issuer takes them
 */
`timescale 1ns/10ps

module l1_request_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              l1_req_valid,
    input  tidc_pkg::l1_req_t l1_req,
    output logic              l1_req_ready,
    input  logic              q_pop,
    output logic              q_valid,
    output tidc_pkg::l1_req_t q_head
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    tidc_pkg::l1_req_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign l1_req_ready = (count < CNT_W'(QUEUE_DEPTH));
    assign q_valid      = (count != '0);
    assign q_head       = mem[rd_ptr];

    assign push = l1_req_valid && l1_req_ready;
    assign pop  = q_pop && q_valid;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= l1_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Wrap by hand so odd depths work too
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== design/tidc_pkg.sv ====
/*
 * Shared widths, opcodes and message structs for the L1 TileLink adapter
 */

package tidc_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ADDR_W    = 32;
    localparam int LINE_BITS = 128;
    localparam int SOURCE_W  = 4;
    localparam int SINK_W    = 4;
    localparam int SIZE_W    = 4;
    localparam int PERM_W    = 3;
    // One mask bit per byte of the line
    localparam int MASK_W    = LINE_BITS / 8;

    // Every size field carries log2 of the 16-byte line
    localparam logic [SIZE_W-1:0] LINE_SIZE_LOG2 = 4'd4;

    // ==============================
    // Encodings
    // ==============================
    typedef enum logic [2:0] {
        READ_MISS  = 3'd0,
        WRITE_MISS = 3'd1,
        WRITE_BACK = 3'd2
    } l1_req_kind_e;

    typedef enum logic [2:0] {
        ACQUIRE_BLOCK = 3'd6
    } a_opcode_e;

    typedef enum logic [2:0] {
        RELEASE_DATA = 3'd7
    } c_opcode_e;

    typedef enum logic [2:0] {
        GRANT       = 3'd4,
        GRANT_DATA  = 3'd5,
        RELEASE_ACK = 3'd6
    } d_opcode_e;

    // ==============================
    // Messages
    // ==============================
    typedef struct packed {
        l1_req_kind_e           kind;
        logic [ADDR_W-1:0]      addr;
        logic [PERM_W-1:0]      perm;
        logic [LINE_BITS-1:0]   data;
    } l1_req_t;

    typedef struct packed {
        a_opcode_e              opcode;
        logic [PERM_W-1:0]      param;
        logic [SIZE_W-1:0]      size;
        logic [SOURCE_W-1:0]    source;
        logic [ADDR_W-1:0]      address;
        logic [MASK_W-1:0]      mask;
    } tl_a_msg_t;

    typedef struct packed {
        c_opcode_e              opcode;
        logic [PERM_W-1:0]      param;
        logic [SIZE_W-1:0]      size;
        logic [SOURCE_W-1:0]    source;
        logic [ADDR_W-1:0]      address;
        logic [LINE_BITS-1:0]   data;
    } tl_c_msg_t;

    typedef struct packed {
        d_opcode_e              opcode;
        logic [PERM_W-1:0]      param;
        logic [SIZE_W-1:0]      size;
        logic [SOURCE_W-1:0]    source;
        logic [SINK_W-1:0]      sink;
        logic [LINE_BITS-1:0]   data;
        logic                   error;
    } tl_d_msg_t;

    // Line handed back to the L1 on GrantData
    typedef struct packed {
        logic [LINE_BITS-1:0]   data;
        logic                   error;
    } l1_fill_t;

endpackage
